/* src/wb_pkg.sv */
// Wishbone bus constants
package wb_pkg;

	// data path is one 32-bit word per beat
	localparam int DATA_W = 32;

	// the master sees a flat 32-bit byte address space
	localparam int ADDR_W = 32;

	// one byte enable per lane of the data word
	localparam int SEL_W = 4;

	// width of one byte lane, used when merging partial writes
	localparam int BYTE_W = DATA_W / SEL_W;

	// upper address half selects the peripheral
	localparam int PIDX_W = 16;

	// lowest address bit of the peripheral index field
	localparam int PIDX_LSB = ADDR_W - PIDX_W;

	// only these two indices are mapped, anything above is answered by the interconnect
	localparam int PERIPH_NUM = 2;
	localparam int PERIPH_REG = 0;
	localparam int PERIPH_FIFO = 1;

	// peripherals decode a small local word address from the low bits
	localparam int LADDR_W = 4;

	// the register bank fills the whole local address range
	localparam int REG_NUM = 2 ** LADDR_W;

	// FIFO geometry, the level needs one bit more than the pointers to tell full from empty
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_LVL_W = $clog2(FIFO_DEPTH) + 1;

	// local register map of the FIFO peripheral
	localparam int FIFO_DATA_OFS = 0;
	localparam int FIFO_LEVEL_OFS = 1;

endpackage

/* src/cmd_pkg.sv */
// Command and master state types
package cmd_pkg;

	// operation carried by a command on the valid/ready port
	typedef enum logic [1:0] {
		CMD_READ = 2'd0,
		CMD_WRITE = 2'd1
	} cmd_op_e;

	// bus master sequence for one command
	// idle takes a command, strobe waits for acceptance,
	// wait_ack waits for the slave answer and respond holds the result
	typedef enum logic [1:0] {
		MST_IDLE = 2'd0,
		MST_STROBE = 2'd1,
		MST_WAIT_ACK = 2'd2,
		MST_RESPOND = 2'd3
	} mst_state_e;

endpackage

/* src/wb_bus_if.sv */
// Wishbone B4 pipelined bus
`timescale 1ns/1ps

interface wb_bus_if;
	import wb_pkg::*;

	// cycle and strobe qualify a request, we selects write
	logic cyc;
	logic stb;
	logic we;

	// full byte address on the master side, slaves only decode the low word bits
	logic [ADDR_W-1:0] adr;
	logic [SEL_W-1:0] sel;

	// write data flows towards the slave, read data back to the master
	logic [DATA_W-1:0] dat_w;
	logic [DATA_W-1:0] dat_r;

	// stall holds off a strobe, ack closes one accepted strobe
	logic stall;
	logic ack;

	modport master (
		output cyc, stb, we, adr, sel, dat_w,
		input dat_r, stall, ack
	);

	modport slave (
		input cyc, stb, we, adr, sel, dat_w,
		output dat_r, stall, ack
	);

endinterface

/* src/wb_cmd_master.sv */
// Command driven bus master
`timescale 1ns/1ps

module wb_cmd_master (
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic cmd_valid_i,
	output logic cmd_ready_o,
	input cmd_pkg::cmd_op_e cmd_op_i,
	input logic [wb_pkg::ADDR_W-1:0] cmd_addr_i,
	input logic [wb_pkg::SEL_W-1:0] cmd_sel_i,
	input logic [wb_pkg::DATA_W-1:0] cmd_data_i,
	output logic rsp_valid_o,
	input logic rsp_ready_i,
	output logic [wb_pkg::DATA_W-1:0] rsp_data_o,
	output logic rsp_err_o,
	input logic unmapped_i,
	wb_bus_if.master bus
);
	import wb_pkg::*;
	import cmd_pkg::*;

	mst_state_e state;

	// command captured at the transfer and replayed on the bus
	cmd_op_e op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [SEL_W-1:0] sel_q;
	logic [DATA_W-1:0] data_q;

	// response latched with the ack
	logic [DATA_W-1:0] rsp_data_q;
	logic rsp_err_q;

	logic cmd_take;

	assign cmd_take = cmd_valid_i && cmd_ready_o;

	// only one access is ever in flight, so the handshakes fall out of the state
	assign cmd_ready_o = (state == MST_IDLE);
	assign rsp_valid_o = (state == MST_RESPOND);

	// cyc covers the strobe and the wait for its ack
	assign bus.cyc = (state == MST_STROBE) || (state == MST_WAIT_ACK);
	assign bus.stb = (state == MST_STROBE);
	assign bus.we = (op_q == CMD_WRITE);
	assign bus.adr = addr_q;
	assign bus.sel = sel_q;
	assign bus.dat_w = data_q;

	assign rsp_data_o = rsp_data_q;
	assign rsp_err_o = rsp_err_q;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state <= MST_IDLE;
		end else begin
			case (state)
				MST_IDLE: begin
					if (cmd_valid_i)
						state <= MST_STROBE;
				end
				// the strobe stays up until the slave drops stall
				MST_STROBE: begin
					if (!bus.stall)
						state <= MST_WAIT_ACK;
				end
				MST_WAIT_ACK: begin
					if (bus.ack)
						state <= MST_RESPOND;
				end
				// back-pressure keeps the response and blocks the next command
				MST_RESPOND: begin
					if (rsp_ready_i)
						state <= MST_IDLE;
				end
				default: state <= MST_IDLE;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (cmd_take) begin
			op_q <= cmd_op_i;
			addr_q <= cmd_addr_i;
			sel_q <= cmd_sel_i;
			data_q <= cmd_data_i;
		end
		// writes report zero data, the error bit marks an unmapped peripheral
		if (state == MST_WAIT_ACK && bus.ack) begin
			rsp_data_q <= (op_q == CMD_READ) ? bus.dat_r : '0;
			rsp_err_q <= unmapped_i;
		end
	end

endmodule

/* src/wbx_1master.sv */
// Single master Wishbone interconnect
`timescale 1ns/1ps

module wbx_1master (
	input logic wb_clk_i,
	input logic wb_rst_i,
	wb_bus_if.slave m,
	wb_bus_if.master s [wb_pkg::PERIPH_NUM],
	output logic unmapped_o
);
	import wb_pkg::*;

	logic req;
	logic [PIDX_W-1:0] pidx_q;
	logic [PIDX_W-1:0] pidx;
	logic mapped;
	logic self_ack_q;

	// return signals gathered from the slave buses so they can be indexed
	logic [DATA_W-1:0] per_dat [PERIPH_NUM];
	logic [PERIPH_NUM-1:0] per_ack;
	logic [PERIPH_NUM-1:0] per_stall;

	assign req = m.cyc && m.stb;

	// live index follows the address during a strobe and the held index afterwards
	assign pidx = req ? m.adr[PIDX_LSB +: PIDX_W] : pidx_q;
	assign mapped = (pidx < PIDX_W'(PERIPH_NUM));
	assign unmapped_o = !mapped;

	// the index persists after the strobe so the ack is routed back from the right slave
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i)
			pidx_q <= '0;
		else if (req)
			pidx_q <= m.adr[PIDX_LSB +: PIDX_W];
	end

	// an unmapped index never stalls and is closed one cycle later by the interconnect
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i)
			self_ack_q <= 1'b0;
		else
			self_ack_q <= req && !mapped;
	end

	for (genvar i = 0; i < PERIPH_NUM; i++) begin : g_slave
		// during a strobe the live index is the value the register is about to take,
		// so the new peripheral gets cyc together with its first strobe
		assign s[i].cyc = m.cyc && (pidx == PIDX_W'(i));
		assign s[i].stb = m.stb;
		assign s[i].we = m.we;
		assign s[i].adr = ADDR_W'(m.adr[LADDR_W-1:0]);
		assign s[i].sel = m.sel;
		assign s[i].dat_w = m.dat_w;
		assign per_dat[i] = s[i].dat_r;
		assign per_ack[i] = s[i].ack;
		assign per_stall[i] = s[i].stall;
	end

	// unmapped answers are the default, a mapped index overrides them
	always_comb begin
		m.dat_r = '0;
		m.ack = self_ack_q;
		m.stall = 1'b0;
		for (int i = 0; i < PERIPH_NUM; i++) begin
			if (pidx == PIDX_W'(i)) begin
				m.dat_r = per_dat[i];
				m.ack = per_ack[i];
				m.stall = per_stall[i];
			end
		end
	end

endmodule

/* src/wb_fifo_periph.sv */
// FIFO peripheral
`timescale 1ns/1ps

module wb_fifo_periph (
	input logic wb_clk_i,
	input logic wb_rst_i,
	wb_bus_if.slave bus
);
	import wb_pkg::*;

	logic [DATA_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_LVL_W-1:0] level;

	logic req;
	logic is_data;
	logic is_level;
	logic full;
	logic empty;
	logic stall;
	logic accept;
	logic push;
	logic pop;
	logic ack_q;
	logic [DATA_W-1:0] dat_q;

	assign req = bus.cyc && bus.stb;
	assign is_data = (bus.adr[LADDR_W-1:0] == LADDR_W'(FIFO_DATA_OFS));
	assign is_level = (bus.adr[LADDR_W-1:0] == LADDR_W'(FIFO_LEVEL_OFS));
	assign full = (level == FIFO_LVL_W'(FIFO_DEPTH));
	assign empty = (level == '0);

	// hold the strobe off rather than overflow or underflow the buffer
	assign stall = req && is_data && (bus.we ? full : empty);
	assign accept = req && !stall;
	assign push = accept && bus.we && is_data;
	assign pop = accept && !bus.we && is_data;

	assign bus.stall = stall;
	assign bus.ack = ack_q;
	assign bus.dat_r = dat_q;

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// a single strobe never pushes and pops at once
			if (push)
				level <= level + 1'b1;
			else if (pop)
				level <= level - 1'b1;
		end
	end

	// a level write is acked and dropped, other local addresses read as zero
	always_ff @(posedge wb_clk_i) begin
		if (push)
			mem[wr_ptr] <= bus.dat_w;
		if (accept && !bus.we) begin
			if (is_data)
				dat_q <= mem[rd_ptr];
			else if (is_level)
				dat_q <= DATA_W'(level);
			else
				dat_q <= '0;
		end
	end

endmodule

/* src/wb_reg_periph.sv */
// Register bank peripheral
`timescale 1ns/1ps

module wb_reg_periph (
	input logic wb_clk_i,
	input logic wb_rst_i,
	wb_bus_if.slave bus
);
	import wb_pkg::*;

	logic [DATA_W-1:0] regs [REG_NUM];
	logic [LADDR_W-1:0] ladr;
	logic accept;
	logic ack_q;
	logic [DATA_W-1:0] dat_q;

	assign ladr = bus.adr[LADDR_W-1:0];

	// the bank is always ready, every strobe is taken at once
	assign accept = bus.cyc && bus.stb;

	assign bus.stall = 1'b0;
	assign bus.ack = ack_q;
	assign bus.dat_r = dat_q;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			for (int i = 0; i < REG_NUM; i++)
				regs[i] <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept;
			// only lanes with their sel bit set take the new byte
			if (accept && bus.we) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (bus.sel[b])
						regs[ladr][b*BYTE_W +: BYTE_W] <= bus.dat_w[b*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// read data is registered so it lines up with the ack
	always_ff @(posedge wb_clk_i) begin
		if (accept && !bus.we)
			dat_q <= regs[ladr];
	end

endmodule

/* src/wb_subsys_top.sv */
// Wishbone subsystem top level
`timescale 1ns/1ps

module wb_subsys_top (
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic cmd_valid_i,
	output logic cmd_ready_o,
	input cmd_pkg::cmd_op_e cmd_op_i,
	input logic [wb_pkg::ADDR_W-1:0] cmd_addr_i,
	input logic [wb_pkg::SEL_W-1:0] cmd_sel_i,
	input logic [wb_pkg::DATA_W-1:0] cmd_data_i,
	output logic rsp_valid_o,
	input logic rsp_ready_i,
	output logic [wb_pkg::DATA_W-1:0] rsp_data_o,
	output logic rsp_err_o
);
	import wb_pkg::*;

	// flags an answer that came from the interconnect instead of a peripheral
	logic unmapped;

	wb_bus_if m_bus ();
	wb_bus_if s_bus [PERIPH_NUM] ();

	wb_cmd_master i_master (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.cmd_valid_i(cmd_valid_i),
		.cmd_ready_o(cmd_ready_o),
		.cmd_op_i(cmd_op_i),
		.cmd_addr_i(cmd_addr_i),
		.cmd_sel_i(cmd_sel_i),
		.cmd_data_i(cmd_data_i),
		.rsp_valid_o(rsp_valid_o),
		.rsp_ready_i(rsp_ready_i),
		.rsp_data_o(rsp_data_o),
		.rsp_err_o(rsp_err_o),
		.unmapped_i(unmapped),
		.bus(m_bus)
	);

	wbx_1master i_xbar (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.m(m_bus),
		.s(s_bus),
		.unmapped_o(unmapped)
	);

	wb_reg_periph i_reg (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.bus(s_bus[PERIPH_REG])
	);

	wb_fifo_periph i_fifo (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.bus(s_bus[PERIPH_FIFO])
	);

endmodule

/* bench/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic rst_o
);

	// 20 ns period, first rising edge at 10 ns
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset covers the first ten rising edges and drops just after the tenth
	initial begin
		rst_o = 1'b1;
		repeat (10) @(posedge clk_o);
		#1;
		rst_o = 1'b0;
	end

endmodule

/* bench/wb_subsys_checker.sv */
// Interconnect protocol checks
`timescale 1ns/1ps

module wb_subsys_checker (
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic m_cyc_i,
	input logic m_stb_i,
	input logic m_stall_i,
	input logic m_ack_i,
	input logic [wb_pkg::ADDR_W-1:0] m_adr_i,
	input logic [wb_pkg::PERIPH_NUM-1:0] slv_cyc_i
);

	// the decoder opens at most one peripheral cycle at a time
	a_one_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		$onehot0(slv_cyc_i))
		else $error("more than one peripheral cyc is high");

	// every ack closes a strobe of a cycle that is still open
	a_ack_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		m_ack_i |-> m_cyc_i)
		else $error("ack returned to the master outside a bus cycle");

	// no strobe may leave the master in the cycle after a reset edge
	a_stb_after_rst: assert property (@(posedge wb_clk_i)
		wb_rst_i |=> !m_stb_i)
		else $error("strobe high right after reset");

	// a stalled request is repeated unchanged on the next cycle
	a_stall_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(m_cyc_i && m_stb_i && m_stall_i) |=> (m_stb_i && $stable(m_adr_i)))
		else $error("stalled strobe dropped or changed its address");

endmodule

// the master side and both slave cycles of the interconnect are watched
bind wbx_1master wb_subsys_checker i_checker (
	.wb_clk_i(wb_clk_i),
	.wb_rst_i(wb_rst_i),
	.m_cyc_i(m.cyc),
	.m_stb_i(m.stb),
	.m_stall_i(m.stall),
	.m_ack_i(m.ack),
	.m_adr_i(m.adr),
	.slv_cyc_i({s[1].cyc, s[0].cyc})
);

/* bench/wb_subsys_tb.sv */
// Wishbone subsystem testbench
`timescale 1ns/1ps

module wb_subsys_tb;
	import wb_pkg::*;
	import cmd_pkg::*;

	// longest single wait in clock cycles
	localparam int TIMEOUT = 200;

	logic wb_clk;
	logic wb_rst;
	logic cmd_valid;
	logic cmd_ready;
	cmd_op_e cmd_op;
	logic [ADDR_W-1:0] cmd_addr;
	logic [SEL_W-1:0] cmd_sel;
	logic [DATA_W-1:0] cmd_data;
	logic rsp_valid;
	logic rsp_ready;
	logic [DATA_W-1:0] rsp_data;
	logic rsp_err;

	// reference copies of the register bank and of the FIFO contents
	logic [DATA_W-1:0] reg_m [REG_NUM];
	logic [DATA_W-1:0] fifo_m [$];

	// expected responses in command order with the error bit on top
	logic [DATA_W:0] exp_q [$];
	logic [DATA_W:0] exp_rsp;

	// response seen at the previous falling edge while it was held back
	logic held;
	logic [DATA_W:0] held_rsp;

	string test_name;
	logic ready_gaps;
	int lat;

	tb_clock_gen i_clk_gen (
		.clk_o(wb_clk),
		.rst_o(wb_rst)
	);

	wb_subsys_top i_dut (
		.wb_clk_i(wb_clk),
		.wb_rst_i(wb_rst),
		.cmd_valid_i(cmd_valid),
		.cmd_ready_o(cmd_ready),
		.cmd_op_i(cmd_op),
		.cmd_addr_i(cmd_addr),
		.cmd_sel_i(cmd_sel),
		.cmd_data_i(cmd_data),
		.rsp_valid_o(rsp_valid),
		.rsp_ready_i(rsp_ready),
		.rsp_data_o(rsp_data),
		.rsp_err_o(rsp_err)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// peripheral index in the upper half, local word address in the low bits
	function automatic logic [ADDR_W-1:0] addr_of(input int pidx, input int la);
		return (ADDR_W'(pidx) << PIDX_LSB) | ADDR_W'(la);
	endfunction

	// applies one command to the reference state and returns {err, data}
	function automatic logic [DATA_W:0] ref_access(input cmd_op_e op,
			input logic [ADDR_W-1:0] addr, input logic [SEL_W-1:0] sel,
			input logic [DATA_W-1:0] data);
		logic [PIDX_W-1:0] pidx;
		logic [LADDR_W-1:0] la;
		logic [DATA_W-1:0] rd;
		pidx = addr[ADDR_W-1 -: PIDX_W];
		la = addr[LADDR_W-1:0];
		rd = '0;
		// indices past the last peripheral answer zero with the error flag
		if (pidx >= PIDX_W'(PERIPH_NUM))
			return {1'b1, rd};
		if (pidx == PIDX_W'(PERIPH_REG)) begin
			// a write only replaces the bytes whose enable is set
			if (op == CMD_WRITE) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (sel[b])
						reg_m[la][b*BYTE_W +: BYTE_W] = data[b*BYTE_W +: BYTE_W];
				end
			end else begin
				rd = reg_m[la];
			end
		end else if (la == LADDR_W'(FIFO_DATA_OFS)) begin
			if (op == CMD_WRITE)
				fifo_m.push_back(data);
			else
				rd = fifo_m.pop_front();
		end else if (la == LADDR_W'(FIFO_LEVEL_OFS) && op == CMD_READ) begin
			rd = DATA_W'(fifo_m.size());
		end
		return {1'b0, rd};
	endfunction

	// called just after a rising edge and returns just after the transfer edge
	task automatic send_cmd(input cmd_op_e op, input logic [ADDR_W-1:0] addr,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] data,
			input logic track);
		int waited;
		waited = 0;
		cmd_op = op;
		cmd_addr = addr;
		cmd_sel = sel;
		cmd_data = data;
		cmd_valid = 1'b1;
		@(negedge wb_clk);
		while (!cmd_ready) begin
			waited++;
			if (waited > TIMEOUT)
				stop_on_error("a command was never accepted by the DUT");
			@(negedge wb_clk);
		end
		// ready is high here, so the command transfers at the coming edge
		if (track)
			exp_q.push_back(ref_access(op, addr, sel, data));
		@(posedge wb_clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic wait_reset();
		int waited;
		waited = 0;
		@(posedge wb_clk);
		while (wb_rst) begin
			waited++;
			if (waited > TIMEOUT)
				stop_on_error("reset was never released");
			@(posedge wb_clk);
		end
		#1;
	endtask

	// waits until every tracked command has been answered
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > TIMEOUT)
				stop_on_error({"responses of test ", test_name, " never arrived"});
			@(posedge wb_clk);
			#1;
		end
	endtask

	// response back-pressure with random gaps only while enabled
	initial begin
		rsp_ready = 1'b1;
		forever begin
			@(posedge wb_clk);
			#1;
			rsp_ready = ready_gaps ? ($urandom_range(0, 3) != 0) : 1'b1;
		end
	end

	// port values are stable at the falling edge and transfer at the next rising one
	always @(negedge wb_clk) begin
		if (wb_rst) begin
			held = 1'b0;
		end else begin
			if (held) begin
				assert (rsp_valid && {rsp_err, rsp_data} == held_rsp)
				else stop_on_error($sformatf(
					"Error: %s held response expected %h actual %0b %h",
					test_name, held_rsp, rsp_valid, {rsp_err, rsp_data}));
			end
			if (rsp_valid) begin
				assert (!cmd_ready)
				else stop_on_error("the command port was ready while a response was pending");
			end
			if (rsp_valid && rsp_ready) begin
				assert (exp_q.size() != 0)
				else stop_on_error({"a response arrived with no command pending in ",
					test_name});
				exp_rsp = exp_q.pop_front();
				assert ({rsp_err, rsp_data} == exp_rsp)
				else stop_on_error($sformatf(
					"Error: %s expected err %0b data %h actual err %0b data %h",
					test_name, exp_rsp[DATA_W], exp_rsp[DATA_W-1:0], rsp_err, rsp_data));
			end
			held = rsp_valid && !rsp_ready;
			held_rsp = {rsp_err, rsp_data};
		end
	end

	initial begin
		void'($urandom(32'h4bbbc032));
		cmd_valid = 1'b0;
		cmd_op = CMD_READ;
		cmd_addr = '0;
		cmd_sel = '0;
		cmd_data = '0;
		ready_gaps = 1'b0;
		test_name = "reset";
		for (int i = 0; i < REG_NUM; i++)
			reg_m[i] = '0;
		wait_reset();

		// the register bank never stalls, so the first answer comes three cycles on
		test_name = "first_latency";
		send_cmd(CMD_READ, addr_of(PERIPH_REG, 0), '1, '0, 1'b1);
		lat = 0;
		do begin
			@(negedge wb_clk);
			lat++;
		end while (!rsp_valid && lat < TIMEOUT);
		assert (lat == 3)
		else stop_on_error($sformatf("Error: %s expected 3 cycles actual %0d", test_name, lat));
		// later commands start from the drive point just after a rising edge
		@(posedge wb_clk);
		#1;
		drain();

		// two rounds of partial writes so later merges start from nonzero words
		test_name = "reg_byte_lanes";
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < REG_NUM; i++)
				send_cmd(CMD_WRITE, addr_of(PERIPH_REG, i), SEL_W'($urandom), $urandom, 1'b1);
		end
		for (int i = 0; i < REG_NUM; i++)
			send_cmd(CMD_READ, addr_of(PERIPH_REG, i), '1, '0, 1'b1);
		drain();

		// five pushes, level, five pops in order, level again
		test_name = "fifo_order";
		for (int i = 0; i < 5; i++)
			send_cmd(CMD_WRITE, addr_of(PERIPH_FIFO, FIFO_DATA_OFS), '1, $urandom, 1'b1);
		send_cmd(CMD_READ, addr_of(PERIPH_FIFO, FIFO_LEVEL_OFS), '1, '0, 1'b1);
		for (int i = 0; i < 5; i++)
			send_cmd(CMD_READ, addr_of(PERIPH_FIFO, FIFO_DATA_OFS), '1, '0, 1'b1);
		send_cmd(CMD_READ, addr_of(PERIPH_FIFO, FIFO_LEVEL_OFS), '1, '0, 1'b1);
		drain();

		test_name = "unmapped_index";
		send_cmd(CMD_WRITE, addr_of(2, 0), '1, $urandom, 1'b1);
		send_cmd(CMD_READ, addr_of(2, 3), '1, '0, 1'b1);
		send_cmd(CMD_READ, addr_of(16'hffff, 1), '1, '0, 1'b1);
		send_cmd(CMD_READ, addr_of(PERIPH_REG, 5), '1, '0, 1'b1);
		drain();

		// mixed traffic under random back-pressure leaves the FIFO alone
		test_name = "backpressure";
		ready_gaps = 1'b1;
		for (int i = 0; i < 40; i++)
			send_cmd($urandom_range(0, 1) ? CMD_WRITE : CMD_READ,
				addr_of($urandom_range(0, 1) ? PERIPH_REG : 3, $urandom_range(0, REG_NUM - 1)),
				SEL_W'($urandom), $urandom, 1'b1);
		drain();
		ready_gaps = 1'b0;

		// with one access in flight the master cannot pop behind a stalled push,
		// so the full FIFO case runs last and only checks that the push is held off
		test_name = "fifo_full";
		for (int i = 0; i < FIFO_DEPTH; i++)
			send_cmd(CMD_WRITE, addr_of(PERIPH_FIFO, FIFO_DATA_OFS), '1, $urandom, 1'b1);
		send_cmd(CMD_READ, addr_of(PERIPH_FIFO, FIFO_LEVEL_OFS), '1, '0, 1'b1);
		drain();
		send_cmd(CMD_WRITE, addr_of(PERIPH_FIFO, FIFO_DATA_OFS), '1, $urandom, 1'b0);
		for (int i = 0; i < 16; i++) begin
			@(negedge wb_clk);
			assert (i_dut.m_bus.stall && !cmd_ready && !rsp_valid)
			else stop_on_error("a write to the full FIFO was not held off by stall");
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* sim.f */
src/wb_pkg.sv
src/cmd_pkg.sv
src/wb_bus_if.sv
src/wb_cmd_master.sv
src/wbx_1master.sv
src/wb_fifo_periph.sv
src/wb_reg_periph.sv
src/wb_subsys_top.sv
bench/tb_clock_gen.sv
bench/wb_subsys_checker.sv
bench/wb_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the subsystem testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module wb_subsys_tb -f sim.f -o wb_subsys_sim \
	|| exit 1
# an assertion stop or crash ends without a verdict line, note it in the log
./obj_dir/wb_subsys_sim > sim.log 2>&1 || echo "simulation ended with an error status" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0
